// File: build.f
+incdir+common
common/cpu_pkg.sv
source/reg_bank.sv
source/fetch_stage.sv
execute/alu.sv
execute/execute_stage.sv
source/writeback_stage.sv
source/cpu_top.sv
verif/cpu_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module cpu_tb -o cpu_sim

./obj_dir/cpu_sim | tee sim.log

if grep -qx "TEST PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: verif/cpu_tb.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_tb;

    localparam int CLOCK_PERIOD = 20;
    localparam int RESET_CYCLES = 4;
    localparam int MEM_WORDS    = 256;
    localparam int LOG_DEPTH    = 512;
    localparam int NUM_TESTS    = 6;
    // instructions emitted over all six programs
    localparam int TOTAL_INSTR  = 83;
    localparam int WATCHDOG_NS  =
        (TOTAL_INSTR * 3 + NUM_TESTS * (RESET_CYCLES + 40)) * CLOCK_PERIOD;

    logic           clock = 1'b0;
    logic           arst_n;
    cpu_pkg::word_t data;
    cpu_pkg::word_t address;
    cpu_pkg::word_t datao;
    logic           rw;

    cpu_pkg::word_t mem [MEM_WORDS];
    cpu_pkg::word_t store_addr_log [LOG_DEPTH];
    cpu_pkg::word_t store_data_log [LOG_DEPTH];
    int             store_cycle_log [LOG_DEPTH];
    int             store_count = 0;
    int             cycle_count;

    logic [31:0]    lfsr_state = 32'h427b_b09c;
    int             prog_pc;
    int             halt_pc;
    int             store_base;
    cpu_pkg::word_t exp_addr [$];
    cpu_pkg::word_t exp_data [$];
    int             exp_cycle [$];
    cpu_pkg::word_t forbidden [$];
    string          test_name;
    int             test_errors;
    int             errors;
    int             checks;
    int             tests_run;
    int             tests_failed;

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    cpu_top u_dut (
        .clock   (clock),
        .arst_n  (arst_n),
        .data    (data),
        .address (address),
        .datao   (datao),
        .rw      (rw)
    );

    // memory answers in the same cycle
    assign data = mem[address[7:0]];

    // cycle 0 ends at the first edge after reset release
    always @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
            cycle_count <= 0;
        else
            cycle_count <= cycle_count + 1;
    end

    always @(posedge clock)
    begin
        if (arst_n && !rw)
        begin
            mem[address[7:0]] = datao;
            if (store_count < LOG_DEPTH)
            begin
                store_addr_log[store_count]  <= address;
                store_data_log[store_count]  <= datao;
                store_cycle_log[store_count] <= cycle_count;
            end
            store_count <= store_count + 1;
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_bits(input int width, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < width; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    task automatic note_failure;
        errors++;
        test_errors++;
    endtask

    task automatic check_word(input string what, input cpu_pkg::word_t expected,
                              input cpu_pkg::word_t actual);
        checks++;
        if (actual !== expected)
        begin
            $display("[ERROR] %s %s: expected %h actual %h", test_name, what, expected, actual);
            note_failure();
        end
    endtask

    task automatic check_bit(input string what, input logic expected, input logic actual);
        checks++;
        if (actual !== expected)
        begin
            $display("[ERROR] %s %s: expected %b actual %b", test_name, what, expected, actual);
            note_failure();
        end
    endtask

    function automatic cpu_pkg::word_t encode(input cpu_pkg::opcode_t op,
                                              input cpu_pkg::reg_idx_t rd,
                                              input cpu_pkg::reg_idx_t ra,
                                              input cpu_pkg::reg_idx_t rb,
                                              input logic highlow, input logic [31:0] imm);
        cpu_pkg::instr_t ins;
        ins = '0;
        ins.opcode  = op;
        ins.ra      = ra;
        ins.rb      = rb;
        ins.rd      = rd;
        ins.highlow = highlow;
        ins.imm     = imm;
        return cpu_pkg::word_t'(ins);
    endfunction

    task automatic emit(input cpu_pkg::word_t w);
        mem[prog_pc] = w;
        prog_pc++;
    endtask

    task automatic load_imm(input cpu_pkg::reg_idx_t rd, input logic [31:0] imm);
        emit(encode(cpu_pkg::OP_LDI, rd, 3'd0, 3'd0, 1'b0, imm));
    endtask

    task automatic load_high(input cpu_pkg::reg_idx_t rd, input cpu_pkg::reg_idx_t ra,
                             input logic [31:0] imm);
        emit(encode(cpu_pkg::OP_LDI, rd, ra, 3'd0, 1'b1, imm));
    endtask

    task automatic load_random(input cpu_pkg::reg_idx_t rd, output cpu_pkg::word_t value);
        logic [31:0] low;
        logic [31:0] high;
        random_bits(32, low);
        random_bits(32, high);
        load_imm(rd, low);
        load_high(rd, rd, high);
        value = {high, low};
    endtask

    task automatic apply_op(input cpu_pkg::opcode_t op, input cpu_pkg::reg_idx_t rd,
                            input cpu_pkg::reg_idx_t ra, input cpu_pkg::reg_idx_t rb);
        emit(encode(op, rd, ra, rb, 1'b0, 32'd0));
    endtask

    task automatic store_reg(input cpu_pkg::reg_idx_t ra, input logic [31:0] addr);
        emit(encode(cpu_pkg::OP_STORE, 3'd0, ra, 3'd0, 1'b0, addr));
    endtask

    task automatic branch_on_flag(input cpu_pkg::reg_idx_t fl, input logic [31:0] target);
        emit(encode(cpu_pkg::OP_BRF, 3'd0, fl, 3'd0, 1'b0, target));
    endtask

    task automatic jump_to(input logic [31:0] target);
        emit(encode(cpu_pkg::OP_JMP, 3'd0, 3'd0, 3'd0, 1'b0, target));
    endtask

    // a jump to itself parks the core once the program is done
    task automatic halt_here;
        halt_pc = prog_pc;
        jump_to(32'(prog_pc));
    endtask

    task automatic expect_store(input logic [31:0] addr, input cpu_pkg::word_t value,
                                input int cycle);
        exp_addr.push_back(cpu_pkg::word_t'(addr));
        exp_data.push_back(value);
        exp_cycle.push_back(cycle);
    endtask

    // unused words hold an address-tagged no-op
    task automatic clear_program;
        cpu_pkg::word_t w;
        for (int i = 0; i < MEM_WORDS; i++)
        begin
            w = '0;
            w[5:0]   = 6'd63;
            w[63:32] = 32'h5a5a_0000 | 32'(i);
            mem[i] = w;
        end
        prog_pc = 0;
        exp_addr.delete();
        exp_data.delete();
        exp_cycle.delete();
        forbidden.delete();
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
        @(posedge clock);
        #2;
        arst_n = 1'b0;
        clear_program();
    endtask

    task automatic check_port_idle(input string when);
        check_bit({"rw ", when}, 1'b1, rw);
        check_word({"address ", when}, '0, address);
        check_word({"datao ", when}, '0, datao);
    endtask

    task automatic release_reset(input bit check_port);
        repeat (RESET_CYCLES)
        begin
            @(negedge clock);
            if (check_port)
                check_port_idle("in reset");
        end
        @(posedge clock);
        #2;
        arst_n = 1'b1;
        store_base = store_count;
    endtask

    task automatic check_stores;
        int seen;
        int idx;
        seen = store_count - store_base;
        if (seen != exp_addr.size())
        begin
            $display("test %s: expected %0d stores but the memory saw %0d",
                     test_name, exp_addr.size(), seen);
            note_failure();
        end
        for (int i = 0; i < exp_addr.size() && i < seen && store_base + i < LOG_DEPTH; i++)
        begin
            idx = store_base + i;
            check_word("store address", exp_addr[i], store_addr_log[idx]);
            check_word("store data", exp_data[i], store_data_log[idx]);
            if (exp_cycle[i] >= 0)
                check_word("store cycle", cpu_pkg::word_t'(exp_cycle[i]),
                           cpu_pkg::word_t'(store_cycle_log[idx]));
        end
        for (int i = 0; i < seen && store_base + i < LOG_DEPTH; i++)
        begin
            foreach (forbidden[j])
            begin
                if (store_addr_log[store_base + i] === forbidden[j])
                begin
                    $display("test %s: a store reached skipped address %h",
                             test_name, forbidden[j]);
                    note_failure();
                end
            end
        end
    endtask

    task automatic run_to_halt;
        int limit;
        bit reached;
        limit   = 3 * prog_pc + 20;
        reached = 1'b0;
        for (int i = 0; i < limit && !reached; i++)
        begin
            @(negedge clock);
            if (rw === 1'b1 && address === cpu_pkg::word_t'(halt_pc))
                reached = 1'b1;
        end
        if (!reached)
        begin
            $display("test %s: program never reached its halt loop within %0d cycles",
                     test_name, limit);
            note_failure();
        end
        check_stores();
        tests_run++;
        if (test_errors == 0)
        begin
            $display("test %s: ok", test_name);
        end
        else
        begin
            tests_failed++;
            $display("test %s: failed with %0d errors", test_name, test_errors);
        end
    endtask

    task automatic test_reset;
        begin_test("reset");
        // the bank clears, so r3 stores zero in cycle 2
        store_reg(3'd3, 32'h10);
        halt_here();
        expect_store(32'h10, '0, 2);
        release_reset(1'b1);
        @(negedge clock);
        check_port_idle("first fetch");
        run_to_halt();
    endtask

    task automatic test_alu_ops;
        cpu_pkg::word_t a;
        cpu_pkg::word_t b;
        begin_test("alu ops");
        load_random(3'd1, a);
        load_random(3'd2, b);
        apply_op(cpu_pkg::OP_ADD, 3'd3, 3'd1, 3'd2);
        store_reg(3'd3, 32'h20);
        expect_store(32'h20, a + b, -1);
        apply_op(cpu_pkg::OP_SUB, 3'd3, 3'd1, 3'd2);
        store_reg(3'd3, 32'h21);
        expect_store(32'h21, a - b, -1);
        apply_op(cpu_pkg::OP_AND, 3'd3, 3'd1, 3'd2);
        store_reg(3'd3, 32'h22);
        expect_store(32'h22, a & b, -1);
        apply_op(cpu_pkg::OP_OR, 3'd3, 3'd1, 3'd2);
        store_reg(3'd3, 32'h23);
        expect_store(32'h23, a | b, -1);
        apply_op(cpu_pkg::OP_XOR, 3'd3, 3'd1, 3'd2);
        store_reg(3'd3, 32'h24);
        expect_store(32'h24, a ^ b, -1);
        apply_op(cpu_pkg::OP_SHL, 3'd3, 3'd1, 3'd2);
        store_reg(3'd3, 32'h25);
        expect_store(32'h25, a << b[5:0], -1);
        halt_here();
        release_reset(1'b0);
        run_to_halt();
    endtask

    task automatic test_high_load;
        logic [31:0] low;
        logic [31:0] high;
        logic [31:0] high2;
        begin_test("high load");
        random_bits(32, low);
        random_bits(32, high);
        random_bits(32, high2);
        load_imm(3'd5, low);
        load_high(3'd5, 3'd5, high);
        store_reg(3'd5, 32'h28);
        // a different source register supplies the low half
        load_high(3'd6, 3'd5, high2);
        store_reg(3'd6, 32'h29);
        halt_here();
        expect_store(32'h28, {high, low}, -1);
        expect_store(32'h29, {high2, low}, -1);
        release_reset(1'b0);
        run_to_halt();
    endtask

    task automatic compare_case(input cpu_pkg::opcode_t op, input cpu_pkg::reg_idx_t fl,
                                input cpu_pkg::reg_idx_t ra, input cpu_pkg::reg_idx_t rb,
                                input cpu_pkg::word_t a_val, input cpu_pkg::word_t b_val,
                                input logic [31:0] marker, input cpu_pkg::word_t marker_val);
        logic taken;
        if (op == cpu_pkg::OP_CMPEQ)
            taken = (a_val == b_val);
        else
            taken = (a_val < b_val);
        apply_op(op, fl, ra, rb);
        branch_on_flag(fl, 32'(prog_pc + 2));
        store_reg(3'd1, marker);
        if (!taken)
            expect_store(marker, marker_val, -1);
    endtask

    task automatic test_compare_branch;
        logic [31:0] v;
        logic [31:0] h;
        cpu_pkg::word_t small_val;
        cpu_pkg::word_t large_val;
        begin_test("compare branch");
        random_bits(32, v);
        random_bits(32, h);
        h[0]      = 1'b1;
        small_val = {32'd0, v};
        large_val = {h, v};
        load_imm(3'd1, v);
        load_imm(3'd2, v);
        load_high(3'd3, 3'd1, h);
        compare_case(cpu_pkg::OP_CMPEQ, 3'd1, 3'd1, 3'd2, small_val, small_val, 32'h30,
                     small_val);
        compare_case(cpu_pkg::OP_CMPEQ, 3'd2, 3'd1, 3'd3, small_val, large_val, 32'h31,
                     small_val);
        compare_case(cpu_pkg::OP_CMPLT, 3'd3, 3'd1, 3'd3, small_val, large_val, 32'h32,
                     small_val);
        compare_case(cpu_pkg::OP_CMPLT, 3'd4, 3'd3, 3'd1, large_val, small_val, 32'h33,
                     small_val);
        compare_case(cpu_pkg::OP_CMPLT, 3'd5, 3'd1, 3'd2, small_val, small_val, 32'h34,
                     small_val);
        halt_here();
        release_reset(1'b0);
        run_to_halt();
    endtask

    task automatic test_jump_timing;
        cpu_pkg::word_t v;
        begin_test("jump timing");
        load_random(3'd1, v);
        for (int k = 0; k < 3; k++)
        begin
            expect_store(32'h40 + 32'(k), v, 3 * prog_pc + 2);
            store_reg(3'd1, 32'h40 + 32'(k));
        end
        jump_to(32'(prog_pc + 2));
        forbidden.push_back(cpu_pkg::word_t'(32'h4f));
        store_reg(3'd1, 32'h4f);
        // one slot skipped, so this store issues one instruction earlier
        expect_store(32'h43, v, 3 * (prog_pc - 1) + 2);
        store_reg(3'd1, 32'h43);
        halt_here();
        release_reset(1'b0);
        run_to_halt();
    endtask

    task automatic test_noop_isolation;
        cpu_pkg::word_t model [8];
        cpu_pkg::word_t w;
        logic [31:0]    fields;
        logic [31:0]    imm;
        begin_test("noop isolation");
        for (int i = 0; i < 8; i++)
            load_random(cpu_pkg::reg_idx_t'(i), model[i]);
        for (int i = 0; i < 5; i++)
        begin
            random_bits(10, fields);
            random_bits(32, imm);
            w = encode(cpu_pkg::OP_ADD, fields[2:0], fields[5:3], fields[8:6], fields[9], imm);
            // opcodes 12 to 63 fall outside the instruction set
            w[5:0] = 6'(12 + 12 * i);
            emit(w);
        end
        for (int i = 0; i < 8; i++)
        begin
            expect_store(32'h50 + 32'(i), model[i], -1);
            store_reg(cpu_pkg::reg_idx_t'(i), 32'h50 + 32'(i));
        end
        halt_here();
        release_reset(1'b0);
        run_to_halt();
    endtask

    initial
    begin
        arst_n       = 1'b0;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        clear_program();
        test_reset();
        test_alu_ops();
        test_high_load();
        test_compare_branch();
        test_jump_timing();
        test_noop_isolation();
        $display("tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: source/cpu_top.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_top
(
    input  wire logic             clock,
    input  wire logic             arst_n,
    input  wire cpu_pkg::word_t   data,
    output cpu_pkg::word_t        address,
    output cpu_pkg::word_t        datao,
    output logic                  rw
);

    cpu_pkg::phase_t       phase;
    cpu_pkg::instr_t       instr;
    cpu_pkg::word_t        pc;
    cpu_pkg::word_t        reg_a;
    cpu_pkg::word_t        reg_b;
    logic                  flag_a;
    cpu_pkg::exec_result_t result;
    logic                  gpr_wr_en;
    logic                  flag_wr_en;
    cpu_pkg::reg_idx_t     wr_idx;
    cpu_pkg::word_t        gpr_wr_data;
    logic                  flag_wr_data;
    logic                  store_en;
    cpu_pkg::word_t        store_addr;
    logic                  pc_load;
    cpu_pkg::word_t        next_pc;

    fetch_stage u_fetch (
        .clock      (clock),
        .arst_n     (arst_n),
        .data       (data),
        .pc_load    (pc_load),
        .next_pc    (next_pc),
        .store_en   (store_en),
        .store_addr (store_addr),
        .phase      (phase),
        .instr      (instr),
        .pc         (pc),
        .address    (address),
        .rw         (rw)
    );

    reg_bank #(.entry_t(cpu_pkg::word_t)) gpr_bank (
        .clock    (clock),
        .arst_n   (arst_n),
        .rd_idx_a (instr.ra),
        .rd_idx_b (instr.rb),
        .rd_a     (reg_a),
        .rd_b     (reg_b),
        .wr_en    (gpr_wr_en),
        .wr_idx   (wr_idx),
        .wr_data  (gpr_wr_data)
    );

    // only the ra flag feeds the branch
    reg_bank #(.entry_t(logic)) flag_bank (
        .clock    (clock),
        .arst_n   (arst_n),
        .rd_idx_a (instr.ra),
        .rd_idx_b (instr.rb),
        .rd_a     (flag_a),
        .rd_b     (),
        .wr_en    (flag_wr_en),
        .wr_idx   (wr_idx),
        .wr_data  (flag_wr_data)
    );

    execute_stage u_execute (
        .clock  (clock),
        .arst_n (arst_n),
        .phase  (phase),
        .instr  (instr),
        .reg_a  (reg_a),
        .reg_b  (reg_b),
        .flag_a (flag_a),
        .result (result)
    );

    writeback_stage u_writeback (
        .phase        (phase),
        .result       (result),
        .pc           (pc),
        .gpr_wr_en    (gpr_wr_en),
        .flag_wr_en   (flag_wr_en),
        .wr_idx       (wr_idx),
        .gpr_wr_data  (gpr_wr_data),
        .flag_wr_data (flag_wr_data),
        .store_en     (store_en),
        .store_addr   (store_addr),
        .store_data   (datao),
        .pc_load      (pc_load),
        .next_pc      (next_pc)
    );

endmodule

`default_nettype wire

// File: source/writeback_stage.sv
`timescale 1ns/10ps
`default_nettype none

module writeback_stage
(
    input  wire cpu_pkg::phase_t        phase,
    input  wire cpu_pkg::exec_result_t  result,
    input  wire cpu_pkg::word_t         pc,
    output logic                        gpr_wr_en,
    output logic                        flag_wr_en,
    output cpu_pkg::reg_idx_t           wr_idx,
    output cpu_pkg::word_t              gpr_wr_data,
    output logic                        flag_wr_data,
    output logic                        store_en,
    output cpu_pkg::word_t              store_addr,
    output cpu_pkg::word_t              store_data,
    output logic                        pc_load,
    output cpu_pkg::word_t              next_pc
);

    logic wb;

    assign wb = (phase == cpu_pkg::WRITEBACK);

    assign gpr_wr_en    = wb && (result.kind == cpu_pkg::KIND_REG);
    assign flag_wr_en   = wb && (result.kind == cpu_pkg::KIND_FLAG);
    assign wr_idx       = result.dest;
    assign gpr_wr_data  = result.value;
    assign flag_wr_data = result.flag;

    assign store_en   = wb && (result.kind == cpu_pkg::KIND_STORE);
    assign store_addr = result.target;
    // datao stays at zero unless a store owns the port
    assign store_data = store_en ? result.value : '0;

    // pc moves once per instruction, at the end of writeback
    assign pc_load = wb;
    assign next_pc = result.redirect ? result.target : pc + cpu_pkg::word_t'(1);

endmodule

`default_nettype wire

// File: execute/execute_stage.sv
`timescale 1ns/10ps
`default_nettype none

module execute_stage
(
    input  wire logic             clock,
    input  wire logic             arst_n,
    input  wire cpu_pkg::phase_t  phase,
    input  wire cpu_pkg::instr_t  instr,
    input  wire cpu_pkg::word_t   reg_a,
    input  wire cpu_pkg::word_t   reg_b,
    input  wire logic             flag_a,
    output cpu_pkg::exec_result_t result
);

    cpu_pkg::word_t        alu_result;
    logic                  alu_flag;
    cpu_pkg::exec_result_t result_next;

    alu u_alu (
        .opcode  (instr.opcode),
        .a       (reg_a),
        .b       (reg_b),
        .imm     (instr.imm),
        .highlow (instr.highlow),
        .result  (alu_result),
        .flag    (alu_flag)
    );

    always_comb
    begin
        result_next.kind     = cpu_pkg::KIND_NONE;
        result_next.redirect = 1'b0;
        result_next.dest     = instr.rd;
        result_next.value    = alu_result;
        result_next.flag     = alu_flag;
        result_next.target   = cpu_pkg::word_t'(instr.imm);
        case (instr.opcode)
            cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_AND, cpu_pkg::OP_OR,
            cpu_pkg::OP_XOR, cpu_pkg::OP_LDI, cpu_pkg::OP_SHL:
                result_next.kind = cpu_pkg::KIND_REG;
            cpu_pkg::OP_STORE:
            begin
                result_next.kind  = cpu_pkg::KIND_STORE;
                result_next.value = reg_a;
            end
            cpu_pkg::OP_CMPEQ, cpu_pkg::OP_CMPLT:
                result_next.kind = cpu_pkg::KIND_FLAG;
            // branch on the flag named by ra
            cpu_pkg::OP_BRF:
                result_next.redirect = flag_a;
            cpu_pkg::OP_JMP:
                result_next.redirect = 1'b1;
            default:
                result_next.kind = cpu_pkg::KIND_NONE;
        endcase
    end

    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
            result <= '0;
        else if (phase == cpu_pkg::EXECUTE)
            result <= result_next;
        else
            result.kind <= cpu_pkg::KIND_NONE;
    end

endmodule

`default_nettype wire

// File: execute/alu.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_macros.svh"

module alu
(
    input  wire cpu_pkg::opcode_t           opcode,
    input  wire cpu_pkg::word_t             a,
    input  wire cpu_pkg::word_t             b,
    input  wire logic [`CPU_IMM_WIDTH-1:0]  imm,
    input  wire logic                       highlow,
    output cpu_pkg::word_t                  result,
    output logic                            flag
);

    localparam int LOW_WIDTH   = `CPU_WORD_WIDTH - `CPU_IMM_WIDTH;
    localparam int SHAMT_WIDTH = $clog2(`CPU_WORD_WIDTH);

    logic [SHAMT_WIDTH-1:0] shamt;

    assign shamt = b[SHAMT_WIDTH-1:0];

    always_comb
    begin
        result = '0;
        flag   = 1'b0;
        case (opcode)
            cpu_pkg::OP_ADD:
                result = a + b;
            cpu_pkg::OP_SUB:
                result = a - b;
            cpu_pkg::OP_AND:
                result = a & b;
            cpu_pkg::OP_OR:
                result = a | b;
            cpu_pkg::OP_XOR:
                result = a ^ b;
            cpu_pkg::OP_LDI:
            begin
                // high load keeps the low half of a
                if (highlow)
                    result = {imm, a[LOW_WIDTH-1:0]};
                else
                    result = {{LOW_WIDTH{1'b0}}, imm};
            end
            cpu_pkg::OP_SHL:
                result = a << shamt;
            cpu_pkg::OP_CMPEQ:
                flag = (a == b);
            // unsigned compare
            cpu_pkg::OP_CMPLT:
                flag = (a < b);
            default:
            begin
                result = '0;
                flag   = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: source/fetch_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_macros.svh"

module fetch_stage
(
    input  wire logic             clock,
    input  wire logic             arst_n,
    input  wire cpu_pkg::word_t   data,
    input  wire logic             pc_load,
    input  wire cpu_pkg::word_t   next_pc,
    input  wire logic             store_en,
    input  wire cpu_pkg::word_t   store_addr,
    output cpu_pkg::phase_t       phase,
    output cpu_pkg::instr_t       instr,
    output cpu_pkg::word_t        pc,
    output cpu_pkg::word_t        address,
    output logic                  rw
);

    cpu_pkg::phase_t phase_next;

    // fixed three-phase sequence, one instruction in flight
    always_comb
    begin
        case (phase)
            cpu_pkg::FETCH:     phase_next = cpu_pkg::EXECUTE;
            cpu_pkg::EXECUTE:   phase_next = cpu_pkg::WRITEBACK;
            cpu_pkg::WRITEBACK: phase_next = cpu_pkg::FETCH;
            default:            phase_next = cpu_pkg::FETCH;
        endcase
    end

    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            phase <= cpu_pkg::FETCH;
            pc    <= cpu_pkg::word_t'(`CPU_RESET_PC);
        end
        else
        begin
            phase <= phase_next;
            if (pc_load)
                pc <= next_pc;
        end
    end

    // memory answers in the same cycle, so the word is taken at the fetch edge
    always_ff @(posedge clock)
    begin
        if (phase == cpu_pkg::FETCH)
            instr <= cpu_pkg::instr_t'(data);
    end

    // the port belongs to the store only for its writeback cycle
    assign address = store_en ? store_addr : pc;
    assign rw      = ~store_en;

    a_store_in_writeback: assert property (
        @(posedge clock) disable iff (!arst_n)
        store_en |-> phase == cpu_pkg::WRITEBACK
    );

    a_pc_load_in_writeback: assert property (
        @(posedge clock) disable iff (!arst_n)
        pc_load |-> phase == cpu_pkg::WRITEBACK
    );

endmodule

`default_nettype wire

// File: source/reg_bank.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_macros.svh"

module reg_bank
#(
    parameter type entry_t = logic
)
(
    input  wire logic               clock,
    input  wire logic               arst_n,
    input  wire cpu_pkg::reg_idx_t  rd_idx_a,
    input  wire cpu_pkg::reg_idx_t  rd_idx_b,
    output entry_t                  rd_a,
    output entry_t                  rd_b,
    input  wire logic               wr_en,
    input  wire cpu_pkg::reg_idx_t  wr_idx,
    input  wire entry_t             wr_data
);

    entry_t entries [`CPU_REG_COUNT];

    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < `CPU_REG_COUNT; i++)
                entries[i] <= entry_t'(0);
        end
        else if (wr_en)
        begin
            entries[wr_idx] <= wr_data;
        end
    end

    // reads are combinational, a write shows up after the edge
    assign rd_a = entries[rd_idx_a];
    assign rd_b = entries[rd_idx_b];

    a_wr_idx_known: assert property (
        @(posedge clock) disable iff (!arst_n)
        wr_en |-> !$isunknown(wr_idx)
    );

endmodule

`default_nettype wire

// File: common/cpu_pkg.sv
`default_nettype none

`include "cpu_macros.svh"

package cpu_pkg;

    typedef logic [`CPU_WORD_WIDTH-1:0] word_t;
    typedef logic [$clog2(`CPU_REG_COUNT)-1:0] reg_idx_t;

    // 0..7 write a register (except store), 8..9 a flag, 10..11 the pc
    typedef enum logic [5:0] {
        OP_ADD   = 6'd0,
        OP_SUB   = 6'd1,
        OP_AND   = 6'd2,
        OP_OR    = 6'd3,
        OP_XOR   = 6'd4,
        OP_LDI   = 6'd5,
        OP_SHL   = 6'd6,
        OP_STORE = 6'd7,
        OP_CMPEQ = 6'd8,
        OP_CMPLT = 6'd9,
        OP_BRF   = 6'd10,
        OP_JMP   = 6'd11
    } opcode_t;

    // bits 31..16 carry nothing
    typedef struct packed {
        logic [`CPU_IMM_WIDTH-1:0]                     imm;
        logic [`CPU_WORD_WIDTH-`CPU_IMM_WIDTH-17:0]    unused;
        logic                                          highlow;
        reg_idx_t                                      rd;
        reg_idx_t                                      rb;
        reg_idx_t                                      ra;
        opcode_t                                       opcode;
    } instr_t;

    typedef enum logic [1:0] {
        FETCH     = 2'd0,
        EXECUTE   = 2'd1,
        WRITEBACK = 2'd2
    } phase_t;

    typedef enum logic [1:0] {
        KIND_NONE  = 2'd0,
        KIND_REG   = 2'd1,
        KIND_FLAG  = 2'd2,
        KIND_STORE = 2'd3
    } result_kind_t;

    typedef struct packed {
        result_kind_t kind;
        logic         redirect;
        reg_idx_t     dest;
        word_t        value;
        logic         flag;
        word_t        target;
    } exec_result_t;

endpackage

`default_nettype wire

// File: common/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// data word and memory address width
`define CPU_WORD_WIDTH 64

// entries in the register bank and in the flag bank
`define CPU_REG_COUNT 8

// immediate field in the upper half of the instruction word
`define CPU_IMM_WIDTH 32

// first fetch address out of reset
`define CPU_RESET_PC 0

`endif
